// File: ckeGenerator.sv
`timescale 1ns/10ps
`default_nettype none

// Free running divider, one cke pulse every div+1 cycles
module ckeGenerator #(
	parameter int pDivWidth = 16
)(
	input  wire                 sysClk,
	input  wire                 rstN,
	input  wire                 en,
	input  wire [pDivWidth-1:0] div,
	output logic                cke
);

	// Divider copy, keeps the compare off the CSR path
	logic [pDivWidth-1:0] divReg;
	logic [pDivWidth-1:0] cnt;
	logic                 hit;

	// Greater-equal also recovers when div shrinks mid count
	assign hit = (cnt >= divReg);
	assign cke = en & hit;

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			divReg <= '0;
			cnt <= '0;
		end
		else
		begin
			divReg <= div;
			// Held at zero while disabled
			if (!en || hit)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

	// Nonzero divider gives at least one idle cycle after each pulse
	assert property (@(posedge sysClk) disable iff (!rstN)
		(cke && div != '0) |=> !cke);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the spiUnit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tbSpiUnit -o simTb

simOut=$(./obj_dir/simTb)
echo "$simOut"
echo "$simOut" | grep -q "^Test OK$"

// File: sources.f
+incdir+.
spiBusPkg.sv
spiFramePkg.sv
ckeGenerator.sv
spiSignal.sv
spiSignalMux.sv
spiUnit.sv
tbSpiUnit.sv

// File: spiBusPkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// Bus side widths and idle values
// ---------------------------------------------------------------------------
package spiBusPkg;

	// Slave frame word, fixed by the SPI protocol
	localparam int FRAME_WORD_W = 32;
	// Bit index inside one frame word
	localparam int WORD_BIT_W = $clog2(FRAME_WORD_W);

	// USI register bus, one frame word per access
	localparam int USI_DATA_W = FRAME_WORD_W;
	// Returned on sMiso when no CSR read runs
	localparam logic [USI_DATA_W-1:0] USI_RD_IDLE = '0;

	// UFI stream bus address is always full width
	localparam int UFI_ADRS_W = 32;
	// Address counter value out of reset
	localparam logic [UFI_ADRS_W-1:0] UFI_ADRS_BASE = '0;

	// ---------------------------------------------------------------------------
	// Master side
	// ---------------------------------------------------------------------------
	// One byte per transfer
	localparam int BYTE_W = 8;
	// Two sck edges per bit
	localparam int HALF_BITS = 2 * BYTE_W;
	localparam int HALF_CNT_W = $clog2(HALF_BITS);

	// Chip select idles high
	localparam logic MCS_IDLE = 1'b1;
	// Receive register out of reset
	localparam logic [BYTE_W-1:0] MRD_RESET = '0;

endpackage

`default_nettype wire

// File: spiFramePkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// Slave frame layout
// ---------------------------------------------------------------------------
package spiFramePkg;

	// Header field widths, MSB first
	localparam int HDR_CMD_W = 2;
	localparam int HDR_CNT_W = 14;
	localparam int HDR_ADRS_W = 16;
	localparam int HDR_W = HDR_CMD_W + HDR_CNT_W + HDR_ADRS_W;

	// Frame commands
	typedef enum logic [HDR_CMD_W-1:0]
	{
		CMD_CSR_WR = 2'd0,
		CMD_CSR_RD = 2'd1,
		CMD_UFI_WR = 2'd2,
		// Words consumed, nothing issued
		CMD_RSVD = 2'd3
	} spiCmdE;

	// First word of a frame
	typedef struct packed
	{
		// Command in the top bits
		spiCmdE cmd;
		// Number of data words after the header
		logic [HDR_CNT_W-1:0] count;
		// Start address, bumped once per data word
		logic [HDR_ADRS_W-1:0] adrs;
	} spiHeaderS;

	// Same word seen as header or as payload
	typedef union packed
	{
		spiHeaderS hdr;
		logic [HDR_W-1:0] data;
	} spiWordU;

endpackage

`default_nettype wire

// File: spiSignal.sv
`timescale 1ns/10ps
`default_nettype none

// SPI pin engine, mode 0 only
module spiSignal
	import spiBusPkg::*;
(
	input  wire                     sysClk,
	input  wire                     rstN,
	input  wire                     msSel,
	input  wire                     spiEn,
	input  wire                     cke,
	input  wire                     mWe,
	input  wire [BYTE_W-1:0]        mWd,
	output logic [BYTE_W-1:0]       mRd,
	output logic                    spiIntr,
	output logic                    busy,
	output logic                    monopoly,
	output logic                    masterSck,
	output logic                    masterCs,
	output logic                    masterMosi,
	input  wire                     masterMiso,
	input  wire                     slaveSck,
	input  wire                     slaveCs,
	input  wire                     slaveMosi,
	output logic                    slaveMiso,
	input  wire [FRAME_WORD_W-1:0]  sMiso,
	output logic [FRAME_WORD_W-1:0] sRd,
	output logic                    sREd,
	output logic                    sFrameStart
);

	// ---------------------------------------------------------------------------
	// Master role, one byte per mWe
	// ---------------------------------------------------------------------------
	logic [BYTE_W-1:0]     mShift;
	logic [HALF_CNT_W-1:0] halfCnt;
	logic                  misoQ;
	logic                  mStart;
	logic                  lastHalf;

	// Only in master role with the unit enabled
	assign mStart = mWe & spiEn & monopoly & ~busy;
	// Sixteenth cke ends the byte on a falling edge
	assign lastHalf = (halfCnt == HALF_CNT_W'(HALF_BITS - 1));
	// MSB leads, low between bytes
	assign masterMosi = busy & mShift[BYTE_W-1];

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			masterSck <= 1'b0;
			masterCs <= MCS_IDLE;
			halfCnt <= '0;
			spiIntr <= 1'b0;
			mRd <= MRD_RESET;
			monopoly <= 1'b0;
		end
		else
		begin
			spiIntr <= 1'b0;
			// Role pin, one flop
			monopoly <= msSel;
			if (mStart)
			begin
				busy <= 1'b1;
				masterCs <= ~MCS_IDLE;
				halfCnt <= '0;
			end
			else if (busy && cke)
			begin
				masterSck <= ~masterSck;
				halfCnt <= halfCnt + 1'b1;
				if (lastHalf)
				begin
					busy <= 1'b0;
					masterCs <= MCS_IDLE;
					spiIntr <= 1'b1;
					// Last sampled bit joins the shifter
					mRd <= {mShift[BYTE_W-2:0], misoQ};
				end
			end
		end
	end

	// Sample on rising sck, shift on falling sck
	always_ff @(posedge sysClk)
	begin
		if (mStart)
			mShift <= mWd;
		else if (busy && cke)
		begin
			if (!masterSck)
				misoQ <= masterMiso;
			else
				mShift <= {mShift[BYTE_W-2:0], misoQ};
		end
	end

	// ---------------------------------------------------------------------------
	// Slave role, 32-bit words from an external master
	// ---------------------------------------------------------------------------
	logic [1:0]              sckSync;
	logic [1:0]              csSync;
	logic [1:0]              mosiSync;
	logic                    sckPrev;
	logic                    csPrev;
	logic                    csLow;
	logic                    sckRise;
	logic                    sckFall;
	logic [WORD_BIT_W-1:0]   bitCnt;
	logic [FRAME_WORD_W-1:0] rxShift;
	logic [FRAME_WORD_W-1:0] txShift;

	assign csLow = ~csSync[1];
	// Edges seen only inside a frame
	assign sckRise = csLow & sckSync[1] & ~sckPrev;
	assign sckFall = csLow & ~sckSync[1] & sckPrev;
	// Frame boundary on either CS edge, a rising CS drops the frame
	assign sFrameStart = csSync[1] ^ csPrev;

	// Word completes on the 32nd rising edge
	assign sRd = {rxShift[FRAME_WORD_W-2:0], mosiSync[1]};
	assign sREd = sckRise & ~monopoly & (&bitCnt);
	assign slaveMiso = txShift[FRAME_WORD_W-1];

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			sckSync <= 2'b00;
			csSync <= 2'b11;
			mosiSync <= 2'b00;
			sckPrev <= 1'b0;
			csPrev <= 1'b1;
			bitCnt <= '0;
		end
		else
		begin
			// Two flop synchronizers
			sckSync <= {sckSync[0], slaveSck};
			csSync <= {csSync[0], slaveCs};
			mosiSync <= {mosiSync[0], slaveMosi};
			sckPrev <= sckSync[1];
			csPrev <= csSync[1];
			// Counter wraps at the word boundary
			if (!csLow)
				bitCnt <= '0;
			else if (sckRise)
				bitCnt <= bitCnt + 1'b1;
		end
	end

	always_ff @(posedge sysClk)
	begin
		if (sckRise)
			rxShift <= sRd;
		// Reply word loaded on the first falling edge of each word
		if (!csLow)
			txShift <= '0;
		else if (sckFall)
		begin
			if (bitCnt == '0)
				txShift <= sMiso;
			else
				txShift <= {txShift[FRAME_WORD_W-2:0], 1'b0};
		end
	end

	// CSR side must wait for spiIntr
	assert property (@(posedge sysClk) disable iff (!rstN) mWe |-> !busy);

	// Word strobe only with CS low at the pin two cycles back
	assert property (@(posedge sysClk) disable iff (!rstN) sREd |-> !$past(slaveCs, 2));

endmodule

`default_nettype wire

// File: spiSignalMux.sv
`timescale 1ns/10ps
`default_nettype none

// Slave frame decoder, bridges words to USI and UFI
module spiSignalMux
	import spiBusPkg::*;
	import spiFramePkg::*;
#(
	parameter int pBusAdrsBit = 16,
	parameter int pUfiBusWidth = 16
)(
	input  wire                     sysClk,
	input  wire                     rstN,
	input  wire                     sFrameStart,
	input  wire                     sREd,
	input  wire [FRAME_WORD_W-1:0]  sRd,
	output logic [FRAME_WORD_W-1:0] sMiso,
	input  wire [USI_DATA_W-1:0]    usiRd,
	output logic [USI_DATA_W-1:0]   usiWd,
	output logic [pBusAdrsBit-1:0]  usiAdrs,
	output logic                    usiWe,
	output logic [pUfiBusWidth-1:0] ufiWd,
	output logic [UFI_ADRS_W-1:0]   ufiAdrs,
	output logic                    ufiWe,
	output logic                    ufiVd
);

	spiWordU                 word;
	spiCmdE                  cmd;
	logic                    hdrSeen;
	logic                    active;
	logic                    advance;
	logic                    dataWord;
	logic [HDR_CNT_W-1:0]    remCnt;
	logic [UFI_ADRS_W-1:0]   adrsCnt;
	logic [FRAME_WORD_W-1:0] dataQ;

	assign word = sRd;
	// Data word still owed by the header
	assign dataWord = sREd & hdrSeen & active;

	// Address shown all the time, bumped the cycle after a strobe
	assign usiAdrs = adrsCnt[pBusAdrsBit-1:0];
	assign ufiAdrs = adrsCnt;
	assign usiWd = dataQ;
	assign ufiWd = dataQ[pUfiBusWidth-1:0];
	// Read data goes back combinationally
	assign sMiso = (active && cmd == CMD_CSR_RD) ? usiRd : USI_RD_IDLE;

	// ---------------------------------------------------------------------------
	// Header and data phase
	// ---------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hdrSeen <= 1'b0;
			active <= 1'b0;
			cmd <= CMD_RSVD;
			remCnt <= '0;
			adrsCnt <= UFI_ADRS_BASE;
			advance <= 1'b0;
			usiWe <= 1'b0;
			ufiWe <= 1'b0;
			ufiVd <= 1'b0;
		end
		else
		begin
			usiWe <= 1'b0;
			ufiWe <= 1'b0;
			advance <= dataWord;
			if (advance)
				adrsCnt <= adrsCnt + 1'b1;
			// Valid drops one cycle after the last stream word
			if (advance && !active)
				ufiVd <= 1'b0;

			if (sFrameStart)
			begin
				hdrSeen <= 1'b0;
				active <= 1'b0;
				ufiVd <= 1'b0;
			end
			else if (sREd && !hdrSeen)
			begin
				hdrSeen <= 1'b1;
				cmd <= word.hdr.cmd;
				remCnt <= word.hdr.count;
				adrsCnt <= UFI_ADRS_W'(word.hdr.adrs);
				active <= (word.hdr.count != '0);
				ufiVd <= (word.hdr.cmd == CMD_UFI_WR) && (word.hdr.count != '0);
			end
			else if (dataWord)
			begin
				remCnt <= remCnt - 1'b1;
				if (remCnt == HDR_CNT_W'(1))
					active <= 1'b0;
				case (cmd)
					CMD_CSR_WR: usiWe <= 1'b1;
					CMD_UFI_WR: ufiWe <= 1'b1;
					// Read only advances, reserved only consumes
					default: ;
				endcase
			end
		end
	end

	// Word payload for both buses
	always_ff @(posedge sysClk)
	begin
		if (dataWord)
			dataQ <= word.data;
	end

	// One command per frame
	assert property (@(posedge sysClk) disable iff (!rstN) !(usiWe && ufiWe));

endmodule

`default_nettype wire

// File: spiUnit.sv
`timescale 1ns/10ps
`default_nettype none

// SPI control unit, master or slave by msSel
module spiUnit
	import spiBusPkg::*;
#(
	parameter int pBusAdrsBit = 16,
	parameter int pDivClk = 16,
	parameter int pUfiBusWidth = 16
)(
	input  wire                     sysClk,
	input  wire                     rstN,
	input  wire                     msSel,
	// Master side CSR
	input  wire                     spiEn,
	input  wire [pDivClk-1:0]       spiDiv,
	input  wire                     mWe,
	input  wire [BYTE_W-1:0]        mWd,
	output logic [BYTE_W-1:0]       mRd,
	output logic                    spiIntr,
	output logic                    busy,
	// Master side pins
	output logic                    masterSck,
	output logic                    masterCs,
	output logic                    masterMosi,
	input  wire                     masterMiso,
	// Slave side pins
	input  wire                     slaveSck,
	input  wire                     slaveCs,
	input  wire                     slaveMosi,
	output logic                    slaveMiso,
	// USI register bus
	output logic                    usiMonopoly,
	input  wire [USI_DATA_W-1:0]    usiRd,
	output logic [USI_DATA_W-1:0]   usiWd,
	output logic [pBusAdrsBit-1:0]  usiAdrs,
	output logic                    usiWe,
	// UFI stream bus
	output logic [pUfiBusWidth-1:0] ufiWd,
	output logic [UFI_ADRS_W-1:0]   ufiAdrs,
	output logic                    ufiWe,
	output logic                    ufiVd
);

	logic                    cke;
	logic [FRAME_WORD_W-1:0] sMiso;
	logic [FRAME_WORD_W-1:0] sRd;
	logic                    sREd;
	logic                    sFrameStart;

	// ---------------------------------------------------------------------------
	// Clock enable, pin engine, bus bridge
	// ---------------------------------------------------------------------------
	ckeGenerator #(
		.pDivWidth (pDivClk)
	) ckeGen (
		.sysClk (sysClk),
		.rstN   (rstN),
		.en     (spiEn),
		.div    (spiDiv),
		.cke    (cke)
	);

	spiSignal spiSig (
		.sysClk      (sysClk),
		.rstN        (rstN),
		.msSel       (msSel),
		.spiEn       (spiEn),
		.cke         (cke),
		.mWe         (mWe),
		.mWd         (mWd),
		.mRd         (mRd),
		.spiIntr     (spiIntr),
		.busy        (busy),
		.monopoly    (usiMonopoly),
		.masterSck   (masterSck),
		.masterCs    (masterCs),
		.masterMosi  (masterMosi),
		.masterMiso  (masterMiso),
		.slaveSck    (slaveSck),
		.slaveCs     (slaveCs),
		.slaveMosi   (slaveMosi),
		.slaveMiso   (slaveMiso),
		.sMiso       (sMiso),
		.sRd         (sRd),
		.sREd        (sREd),
		.sFrameStart (sFrameStart)
	);

	spiSignalMux #(
		.pBusAdrsBit  (pBusAdrsBit),
		.pUfiBusWidth (pUfiBusWidth)
	) spiSigMux (
		.sysClk      (sysClk),
		.rstN        (rstN),
		.sFrameStart (sFrameStart),
		.sREd        (sREd),
		.sRd         (sRd),
		.sMiso       (sMiso),
		.usiRd       (usiRd),
		.usiWd       (usiWd),
		.usiAdrs     (usiAdrs),
		.usiWe       (usiWe),
		.ufiWd       (ufiWd),
		.ufiAdrs     (ufiAdrs),
		.ufiWe       (ufiWe),
		.ufiVd       (ufiVd)
	);

endmodule

`default_nettype wire

// File: tbSpiTasks.svh
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// ---------------------------------------------------------------------------
// Helpers, bus models and the external SPI master
// ---------------------------------------------------------------------------

// Park on falling clock edges
task automatic waitNeg(input int n);
	int i;
	for (i = 0; i < n; i++)
		@(negedge sysClk);
endtask

task automatic flagError(input string msg);
	$display("ERR %0t: %s", $time, msg);
	errors++;
endtask

// Classic 32-bit LCG constants
function automatic logic [31:0] lcgStep(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// Register file seen by CSR reads
function automatic logic [31:0] usiReadModel(input logic [ADRS_BITS-1:0] adrs);
	return 32'(adrs) ^ 32'h5a5a0000;
endfunction

// Command, count, address from the top bit down
function automatic logic [31:0] buildHeader(
	input logic [1:0]  cmd,
	input logic [13:0] count,
	input logic [15:0] adrs
);
	return {cmd, count, adrs};
endfunction

// CS low with sck parked low, mode 0
task automatic beginFrame();
	slaveSck = 1'b0;
	slaveMosi = 1'b0;
	slaveCs = 1'b0;
	waitNeg(SCK_PHASE);
endtask

task automatic endFrame();
	waitNeg(SCK_PHASE);
	slaveCs = 1'b1;
	// CS edge has to pass the synchronizers
	waitNeg(2 * SCK_PHASE);
endtask

// One 32-bit word, MSB first
task automatic shiftWord(input logic [31:0] txWord, output logic [31:0] rxWord);
	int i;
	for (i = 31; i >= 0; i--)
	begin
		// MOSI moves while sck is low
		slaveMosi = txWord[i];
		waitNeg(SCK_PHASE);
		// Master samples MISO on the rising edge
		rxWord[i] = slaveMiso;
		slaveSck = 1'b1;
		waitNeg(SCK_PHASE);
		slaveSck = 1'b0;
	end
endtask

`endif

// File: tbSpiUnit.sv
`timescale 1ns/10ps
`default_nettype none

// Testbench for spiUnit with master loopback and slave frames
module tbSpiUnit
	import spiFramePkg::*;
();

	localparam int ADRS_BITS = 16;
	localparam int DIV_BITS = 16;
	localparam int UFI_BITS = 16;
	localparam int N_TESTS = 9;
	// Slave sck half period in sysClk cycles
	localparam int SCK_PHASE = 6;

	// Expected value counts intr pulses for master and bus strobes for slave
	typedef struct packed
	{
		logic        master;
		logic [1:0]  cmd;
		logic [15:0] div;
		logic [15:0] adrs;
		logic [13:0] count;
		logic [3:0]  sent;
		logic [7:0]  mByte;
		logic [7:0]  expStrobes;
	} testEntryS;

	logic                 sysClk;
	logic                 rstN;
	logic                 msSel;
	logic                 spiEn;
	logic [DIV_BITS-1:0]  spiDiv;
	logic                 mWe;
	logic [7:0]           mWd;
	logic [7:0]           mRd;
	logic                 spiIntr;
	logic                 busy;
	logic                 masterSck;
	logic                 masterCs;
	logic                 masterMosi;
	logic                 masterMiso;
	logic                 slaveSck;
	logic                 slaveCs;
	logic                 slaveMosi;
	logic                 slaveMiso;
	logic                 usiMonopoly;
	logic [31:0]          usiRd;
	logic [31:0]          usiWd;
	logic [ADRS_BITS-1:0] usiAdrs;
	logic                 usiWe;
	logic [UFI_BITS-1:0]  ufiWd;
	logic [31:0]          ufiAdrs;
	logic                 ufiWe;
	logic                 ufiVd;

	testEntryS   testTable[N_TESTS];
	logic [31:0] lcgState;
	logic [31:0] usiAdrsLog[$];
	logic [31:0] usiWdLog[$];
	logic [31:0] ufiAdrsLog[$];
	logic [31:0] ufiWdLog[$];
	int          ufiNoVd;
	int          errors;
	int          failedTests;
	int          errBefore;
	int          cycles;
	int          timeoutLimit;
	int          idx;

	`include "tbSpiTasks.svh"

	// Loopback on the master pins and a combinational register read
	assign masterMiso = masterMosi;
	assign usiRd = usiReadModel(usiAdrs);

	spiUnit #(
		.pBusAdrsBit  (ADRS_BITS),
		.pDivClk      (DIV_BITS),
		.pUfiBusWidth (UFI_BITS)
	) i_spiUnit (
		.sysClk (sysClk), .rstN (rstN), .msSel (msSel),
		.spiEn (spiEn), .spiDiv (spiDiv), .mWe (mWe), .mWd (mWd), .mRd (mRd),
		.spiIntr (spiIntr), .busy (busy),
		.masterSck (masterSck), .masterCs (masterCs),
		.masterMosi (masterMosi), .masterMiso (masterMiso),
		.slaveSck (slaveSck), .slaveCs (slaveCs),
		.slaveMosi (slaveMosi), .slaveMiso (slaveMiso),
		.usiMonopoly (usiMonopoly), .usiRd (usiRd), .usiWd (usiWd),
		.usiAdrs (usiAdrs), .usiWe (usiWe),
		.ufiWd (ufiWd), .ufiAdrs (ufiAdrs), .ufiWe (ufiWe), .ufiVd (ufiVd)
	);

	initial
	begin
		sysClk = 1'b0;
		forever #2 sysClk = ~sysClk;
	end

	// Run limit from the table length
	always @(posedge sysClk)
	begin
		cycles++;
		if (timeoutLimit > 0 && cycles >= timeoutLimit)
		begin
			$display("Run stopped, no finish within %0d cycles", timeoutLimit);
			$display("Test FAILED");
			$finish;
		end
	end

	// Registered bus outputs are steady at the falling edge
	always @(negedge sysClk)
	begin
		if (usiWe)
		begin
			usiAdrsLog.push_back(32'(usiAdrs));
			usiWdLog.push_back(usiWd);
		end
		if (ufiWe)
		begin
			ufiAdrsLog.push_back(ufiAdrs);
			ufiWdLog.push_back(32'(ufiWd));
			if (!ufiVd)
				ufiNoVd++;
		end
	end

	function automatic int worstCycles(input testEntryS t);
		if (t.master)
			return 20 * (int'(t.div) + 1) + 24;
		else
			return (2 + int'(t.sent)) * 64 * SCK_PHASE + 48;
	endfunction

	// ---------------------------------------------------------------------------
	// Master byte with loopback
	// ---------------------------------------------------------------------------
	task automatic runMaster(input testEntryS t);
		int   waited;
		int   sinceEdge;
		int   edges;
		int   pulses;
		int   tail;
		int   csHigh;
		logic prevSck;
		msSel = 1'b1;
		spiEn = 1'b1;
		spiDiv = t.div;
		// Role flop and divider copy settle
		waitNeg(int'(t.div) + 4);
		mWd = t.mByte;
		mWe = 1'b1;
		waitNeg(1);
		mWe = 1'b0;
		prevSck = masterSck;
		waited = 0;
		sinceEdge = 0;
		edges = 0;
		pulses = 0;
		tail = 0;
		csHigh = 0;
		// Watch until a quiet tail after spiIntr
		while (waited < 19 * (int'(t.div) + 1) + 16 && tail < 2 * (int'(t.div) + 1) + 4)
		begin
			waitNeg(1);
			waited++;
			sinceEdge++;
			if (masterSck != prevSck)
			begin
				if (edges > 0 && sinceEdge != int'(t.div) + 1)
					flagError($sformatf("sck edge after %0d cycles, expected %0d",
						sinceEdge, int'(t.div) + 1));
				edges++;
				sinceEdge = 0;
				prevSck = masterSck;
			end
			// Chip select stays low until the byte ends
			if (pulses == 0 && !spiIntr && masterCs)
				csHigh++;
			if (spiIntr)
			begin
				pulses++;
				if (mRd != t.mByte)
					flagError($sformatf("mRd %h, expected %h", mRd, t.mByte));
			end
			if (pulses > 0)
				tail++;
		end
		if (pulses == 0)
			flagError("spiIntr never came, byte transfer did not finish");
		else if (pulses != int'(t.expStrobes))
			flagError($sformatf("%0d spiIntr pulses, expected %0d", pulses, t.expStrobes));
		if (edges != 16)
			flagError($sformatf("%0d sck edges, expected 16", edges));
		if (csHigh != 0)
			flagError($sformatf("masterCs high for %0d cycles during the byte", csHigh));
		if (!masterCs)
			flagError("masterCs low after the byte");
	endtask

	// ---------------------------------------------------------------------------
	// Slave frame from the external master
	// ---------------------------------------------------------------------------
	task automatic runSlave(input testEntryS t);
		logic [31:0] words[16];
		logic [31:0] rxWord;
		int          expUsi;
		int          expUfi;
		int          k;
		msSel = 1'b0;
		spiEn = 1'b0;
		waitNeg(4);
		usiAdrsLog.delete();
		usiWdLog.delete();
		ufiAdrsLog.delete();
		ufiWdLog.delete();
		ufiNoVd = 0;
		beginFrame();
		shiftWord(buildHeader(t.cmd, t.count, t.adrs), rxWord);
		for (k = 0; k < int'(t.sent); k++)
		begin
			lcgState = lcgStep(lcgState);
			words[k] = lcgState;
			shiftWord(words[k], rxWord);
			// Data word k carries the reply for start address plus k
			if (t.cmd == CMD_CSR_RD && rxWord != usiReadModel(ADRS_BITS'(t.adrs + k)))
				flagError($sformatf("read word %0d is %h, expected %h", k, rxWord,
					usiReadModel(ADRS_BITS'(t.adrs + k))));
		end
		endFrame();
		// Clocks with CS high after a cut frame reach neither bus
		if (int'(t.sent) < int'(t.count))
			shiftWord(lcgStep(lcgState), rxWord);
		waitNeg(4);
		expUsi = (t.cmd == CMD_CSR_WR) ? int'(t.expStrobes) : 0;
		expUfi = (t.cmd == CMD_UFI_WR) ? int'(t.expStrobes) : 0;
		if (usiAdrsLog.size() != expUsi)
			flagError($sformatf("%0d usiWe pulses, expected %0d", usiAdrsLog.size(), expUsi));
		if (ufiAdrsLog.size() != expUfi)
			flagError($sformatf("%0d ufiWe pulses, expected %0d", ufiAdrsLog.size(), expUfi));
		for (k = 0; k < usiAdrsLog.size() && k < int'(t.sent); k++)
			if (usiAdrsLog[k] != 32'(ADRS_BITS'(t.adrs + k)) || usiWdLog[k] != words[k])
				flagError($sformatf("usi write %0d at %h data %h, expected %h data %h", k,
					usiAdrsLog[k], usiWdLog[k], ADRS_BITS'(t.adrs + k), words[k]));
		for (k = 0; k < ufiAdrsLog.size() && k < int'(t.sent); k++)
			if (ufiAdrsLog[k] != 32'(t.adrs) + k || ufiWdLog[k] != 32'(words[k][UFI_BITS-1:0]))
				flagError($sformatf("ufi write %0d at %h data %h, expected %h data %h", k,
					ufiAdrsLog[k], ufiWdLog[k], 32'(t.adrs) + k, words[k][UFI_BITS-1:0]));
		if (ufiNoVd != 0)
			flagError("ufiWe pulsed while ufiVd was low");
		if (ufiVd)
			flagError("ufiVd still high after the frame");
	endtask

	initial
	begin
		rstN = 1'b0;
		msSel = 1'b0;
		spiEn = 1'b0;
		spiDiv = '0;
		mWe = 1'b0;
		mWd = '0;
		slaveSck = 1'b0;
		slaveCs = 1'b1;
		slaveMosi = 1'b0;
		errors = 0;
		failedTests = 0;
		cycles = 0;
		ufiNoVd = 0;
		lcgState = 32'hc682f3b6;
		// Role, cmd, div, address, count, words sent, master byte, expected
		testTable[0] = '{1'b1, 2'd0, 16'd0, 16'h0000, 14'd0, 4'd0, 8'ha5, 8'd1};
		testTable[1] = '{1'b1, 2'd0, 16'd1, 16'h0000, 14'd0, 4'd0, 8'h3c, 8'd1};
		testTable[2] = '{1'b1, 2'd0, 16'd5, 16'h0000, 14'd0, 4'd0, 8'he1, 8'd1};
		testTable[3] = '{1'b0, CMD_CSR_WR, 16'd0, 16'h0100, 14'd4, 4'd4, 8'h00, 8'd4};
		testTable[4] = '{1'b0, CMD_CSR_RD, 16'd0, 16'h2340, 14'd3, 4'd3, 8'h00, 8'd0};
		testTable[5] = '{1'b0, CMD_UFI_WR, 16'd0, 16'hfffe, 14'd5, 4'd5, 8'h00, 8'd5};
		testTable[6] = '{1'b0, CMD_RSVD, 16'd0, 16'h0040, 14'd3, 4'd3, 8'h00, 8'd0};
		// Frames cut short by CS rising
		testTable[7] = '{1'b0, CMD_CSR_WR, 16'd0, 16'h0200, 14'd6, 4'd2, 8'h00, 8'd2};
		testTable[8] = '{1'b0, CMD_UFI_WR, 16'd0, 16'h0300, 14'd4, 4'd1, 8'h00, 8'd1};
		timeoutLimit = 40;
		for (idx = 0; idx < N_TESTS; idx++)
			timeoutLimit += worstCycles(testTable[idx]);
		timeoutLimit *= 2;

		repeat (16) @(posedge sysClk);
		@(negedge sysClk);
		rstN = 1'b1;

		// Idle state straight out of reset
		if (spiIntr || usiWe || ufiWe || ufiVd || busy || masterSck)
			flagError("strobe or busy high after reset");
		if (!masterCs || mRd != 8'h00)
			flagError($sformatf("masterCs %b mRd %h after reset", masterCs, mRd));
		msSel = 1'b1;
		waitNeg(1);
		if (usiMonopoly != 1'b1)
			flagError("usiMonopoly did not follow msSel high");
		msSel = 1'b0;
		waitNeg(1);
		if (usiMonopoly != 1'b0)
			flagError("usiMonopoly did not follow msSel low");
		$display("test reset: %s", (errors == 0) ? "pass" : "fail");
		if (errors != 0)
			failedTests++;

		for (idx = 0; idx < N_TESTS; idx++)
		begin
			errBefore = errors;
			if (testTable[idx].master)
				runMaster(testTable[idx]);
			else
				runSlave(testTable[idx]);
			$display("test %0d %s cmd %0d div %0d: %s", idx,
				testTable[idx].master ? "master" : "slave", testTable[idx].cmd,
				testTable[idx].div, (errors == errBefore) ? "pass" : "fail");
			if (errors != errBefore)
				failedTests++;
		end

		$display("%0d tests, %0d failed, %0d errors", N_TESTS + 1, failedTests, errors);
		if (errors == 0 && failedTests == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
